// ==== source/cipher_settings.svh ====
`ifndef CIPHER_SETTINGS_SVH
`define CIPHER_SETTINGS_SVH

// Data word and word address widths
`define CIPHER_DATA_W 32
`define CIPHER_ADDR_W 16

// One job is one block of words
`define CIPHER_BLOCK_WORDS 4
`define CIPHER_IDX_W 2

// Default depth of the word buffer
`define CIPHER_FIFO_DEPTH 4

// Left rotate amount of the word cipher
`define CIPHER_ROT 5

`endif

// ==== source/cipher_pkg.sv ====
`default_nettype none

package cipher_pkg;

  // Job controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_STARTING,
    ST_REQUEST_DATA,
    ST_WORKING,
    ST_DRAIN,
    ST_FINISHED
  } cipher_state_t;

  // Wishbone classic master phase
  typedef enum logic [0:0] {
    WB_IDLE,
    WB_WAIT_ACK
  } wb_phase_t;

endpackage : cipher_pkg

`default_nettype wire

// ==== source/word_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

// Word stream with index, transfer on valid and ready
interface word_stream_if;

  logic                       valid;
  logic                       ready;
  logic [`CIPHER_DATA_W-1:0]  data;
  logic [`CIPHER_IDX_W-1:0]   idx;

  modport producer (
    output valid,
    output data,
    output idx,
    input  ready
  );

  modport consumer (
    input  valid,
    input  data,
    input  idx,
    output ready
  );

endinterface : word_stream_if

`default_nettype wire

// ==== source/cipher_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module cipher_ctrl_fsm
  import cipher_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset_n,
  input  wire logic                       start_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  src_base_i,
  output logic                            fetch_req_o,
  output logic      [`CIPHER_ADDR_W-1:0]  fetch_addr_o,
  output logic      [`CIPHER_IDX_W-1:0]   fetch_idx_o,
  input  wire logic                       fetch_done_i,
  input  wire logic                       word_written_i,
  output logic                            busy_o,
  output logic                            done_o
);

  localparam int CNT_W = `CIPHER_IDX_W + 1;
  localparam logic [`CIPHER_IDX_W-1:0] LAST_IDX = `CIPHER_IDX_W'(`CIPHER_BLOCK_WORDS - 1);
  localparam logic [CNT_W-1:0] ALL_WORDS = CNT_W'(`CIPHER_BLOCK_WORDS);

  cipher_state_t state_q, state_d;

  logic [`CIPHER_IDX_W-1:0]  req_cnt_q;
  logic [CNT_W-1:0]          wr_cnt_q;
  logic [`CIPHER_ADDR_W-1:0] src_base_q;
  logic                      job_start;

  assign job_start = (state_q == ST_IDLE) && start_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and write counters, both restart with a new job
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_cnt_q <= '0;
      wr_cnt_q  <= '0;
    end else begin
      if (job_start) begin
        req_cnt_q <= '0;
        wr_cnt_q  <= '0;
      end else begin
        if (state_q == ST_WORKING && fetch_done_i && req_cnt_q != LAST_IDX) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (word_written_i) begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
        end
      end
    end
  end

  // Source base held for the whole job
  always_ff @(posedge clk) begin
    if (job_start) begin
      src_base_q <= src_base_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_STARTING;
        end
      end
      ST_STARTING: begin
        state_d = ST_REQUEST_DATA;
      end
      ST_REQUEST_DATA: begin
        state_d = ST_WORKING;
      end
      ST_WORKING: begin
        if (fetch_done_i) begin
          state_d = (req_cnt_q == LAST_IDX) ? ST_DRAIN : ST_REQUEST_DATA;
        end
      end
      ST_DRAIN: begin
        if (wr_cnt_q == ALL_WORDS) begin
          state_d = ST_FINISHED;
        end
      end
      ST_FINISHED: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign fetch_req_o  = (state_q == ST_REQUEST_DATA);
  assign fetch_addr_o = src_base_q + {{(`CIPHER_ADDR_W-`CIPHER_IDX_W){1'b0}}, req_cnt_q};
  assign fetch_idx_o  = req_cnt_q;
  assign busy_o       = (state_q != ST_IDLE);
  assign done_o       = (state_q == ST_FINISHED);

endmodule : cipher_ctrl_fsm

`default_nettype wire

// ==== source/word_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module word_fetch_unit
  import cipher_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset_n,
  input  wire logic                       fetch_req_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  fetch_addr_i,
  input  wire logic [`CIPHER_IDX_W-1:0]   fetch_idx_i,
  output logic                            fetch_done_o,
  output logic                            rd_cyc_o,
  output logic                            rd_stb_o,
  output logic      [`CIPHER_ADDR_W-1:0]  rd_adr_o,
  input  wire logic [`CIPHER_DATA_W-1:0]  rd_dat_i,
  input  wire logic                       rd_ack_i,
  word_stream_if.producer                 out_s
);

  wb_phase_t phase_q;
  logic      word_valid_q;

  logic [`CIPHER_ADDR_W-1:0] adr_q;
  logic [`CIPHER_IDX_W-1:0]  idx_q;
  logic [`CIPHER_DATA_W-1:0] data_q;

  logic req_accept;
  logic ack_seen;
  logic word_taken;

  // Controller waits for fetch_done, so a request never meets a busy unit
  assign req_accept = fetch_req_i && (phase_q == WB_IDLE) && !word_valid_q;
  assign ack_seen   = (phase_q == WB_WAIT_ACK) && rd_ack_i;
  assign word_taken = out_s.valid && out_s.ready;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase_q      <= WB_IDLE;
      word_valid_q <= 1'b0;
    end else begin
      if (req_accept) begin
        phase_q <= WB_WAIT_ACK;
      end else if (ack_seen) begin
        phase_q <= WB_IDLE;
      end
      if (ack_seen) begin
        word_valid_q <= 1'b1;
      end else if (word_taken) begin
        word_valid_q <= 1'b0;
      end
    end
  end

  // Request fields and read data
  always_ff @(posedge clk) begin
    if (req_accept) begin
      adr_q <= fetch_addr_i;
      idx_q <= fetch_idx_i;
    end
    if (ack_seen) begin
      data_q <= rd_dat_i;
    end
  end

  // Read cycle, held until ack
  assign rd_cyc_o = (phase_q == WB_WAIT_ACK);
  assign rd_stb_o = (phase_q == WB_WAIT_ACK);
  assign rd_adr_o = adr_q;

  assign out_s.valid = word_valid_q;
  assign out_s.data  = data_q;
  assign out_s.idx   = idx_q;

  assign fetch_done_o = word_taken;

endmodule : word_fetch_unit

`default_nettype wire

// ==== source/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module word_fifo #(
  parameter int DEPTH = `CIPHER_FIFO_DEPTH
) (
  input  wire logic       clk,
  input  wire logic       reset_n,
  word_stream_if.consumer in_s,
  word_stream_if.producer out_s
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [`CIPHER_DATA_W-1:0] mem_data [DEPTH];
  logic [`CIPHER_IDX_W-1:0]  mem_idx  [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign push = in_s.valid && in_s.ready;
  assign pop  = out_s.valid && out_s.ready;

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr_q] <= in_s.data;
      mem_idx[wr_ptr_q]  <= in_s.idx;
    end
  end

  assign in_s.ready  = (count_q != FULL_CNT);
  assign out_s.valid = (count_q != '0);
  assign out_s.data  = mem_data[rd_ptr_q];
  assign out_s.idx   = mem_idx[rd_ptr_q];

endmodule : word_fifo

`default_nettype wire

// ==== source/cipher_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module cipher_writer
  import cipher_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset_n,
  word_stream_if.consumer                 in_s,
  input  wire logic [`CIPHER_ADDR_W-1:0]  dst_base_i,
  input  wire logic [`CIPHER_DATA_W-1:0]  key_i,
  output logic                            wr_cyc_o,
  output logic                            wr_stb_o,
  output logic                            wr_we_o,
  output logic      [`CIPHER_ADDR_W-1:0]  wr_adr_o,
  output logic      [`CIPHER_DATA_W-1:0]  wr_dat_o,
  input  wire logic                       wr_ack_i,
  output logic                            word_written_o
);

  wb_phase_t phase_q;

  logic [`CIPHER_DATA_W-1:0] cipher_q;
  logic [`CIPHER_IDX_W-1:0]  idx_q;

  logic pop;
  logic ack_seen;

  // Key xor, left rotate, then xor with the word index
  function automatic logic [`CIPHER_DATA_W-1:0] encipher(
    input logic [`CIPHER_DATA_W-1:0] plain,
    input logic [`CIPHER_DATA_W-1:0] key,
    input logic [`CIPHER_IDX_W-1:0]  idx
  );
    logic [`CIPHER_DATA_W-1:0] mixed;
    logic [`CIPHER_DATA_W-1:0] rotated;
    mixed   = plain ^ key;
    rotated = (mixed << `CIPHER_ROT) | (mixed >> (`CIPHER_DATA_W - `CIPHER_ROT));
    return rotated ^ {{(`CIPHER_DATA_W-`CIPHER_IDX_W){1'b0}}, idx};
  endfunction

  // Only one word in flight on the write bus
  assign in_s.ready = (phase_q == WB_IDLE);
  assign pop        = in_s.valid && in_s.ready;
  assign ack_seen   = (phase_q == WB_WAIT_ACK) && wr_ack_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase_q <= WB_IDLE;
    end else begin
      case (phase_q)
        WB_IDLE: begin
          if (pop) begin
            phase_q <= WB_WAIT_ACK;
          end
        end
        WB_WAIT_ACK: begin
          if (wr_ack_i) begin
            phase_q <= WB_IDLE;
          end
        end
        default: begin
          phase_q <= WB_IDLE;
        end
      endcase
    end
  end

  // Ciphertext and its index, captured on pop
  always_ff @(posedge clk) begin
    if (pop) begin
      cipher_q <= encipher(in_s.data, key_i, in_s.idx);
      idx_q    <= in_s.idx;
    end
  end

  assign wr_cyc_o = (phase_q == WB_WAIT_ACK);
  assign wr_stb_o = (phase_q == WB_WAIT_ACK);
  assign wr_we_o  = (phase_q == WB_WAIT_ACK);
  assign wr_adr_o = dst_base_i + {{(`CIPHER_ADDR_W-`CIPHER_IDX_W){1'b0}}, idx_q};
  assign wr_dat_o = cipher_q;

  // One pulse per acknowledged write
  assign word_written_o = ack_seen;

endmodule : cipher_writer

`default_nettype wire

// ==== source/cipher_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module cipher_accel_top (
  input  wire logic                       clk,
  input  wire logic                       reset_n,
  input  wire logic                       start_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  src_base_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  dst_base_i,
  input  wire logic [`CIPHER_DATA_W-1:0]  key_i,
  output logic                            busy_o,
  output logic                            done_o,
  // Read bus
  output logic                            rd_cyc_o,
  output logic                            rd_stb_o,
  output logic      [`CIPHER_ADDR_W-1:0]  rd_adr_o,
  input  wire logic [`CIPHER_DATA_W-1:0]  rd_dat_i,
  input  wire logic                       rd_ack_i,
  // Write bus
  output logic                            wr_cyc_o,
  output logic                            wr_stb_o,
  output logic                            wr_we_o,
  output logic      [`CIPHER_ADDR_W-1:0]  wr_adr_o,
  output logic      [`CIPHER_DATA_W-1:0]  wr_dat_o,
  input  wire logic                       wr_ack_i
);

  logic                      fetch_req;
  logic [`CIPHER_ADDR_W-1:0] fetch_addr;
  logic [`CIPHER_IDX_W-1:0]  fetch_idx;
  logic                      fetch_done;
  logic                      word_written;

  word_stream_if fetch_stream ();
  word_stream_if cipher_stream ();

  cipher_ctrl_fsm u_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .start_i        (start_i),
    .src_base_i     (src_base_i),
    .fetch_req_o    (fetch_req),
    .fetch_addr_o   (fetch_addr),
    .fetch_idx_o    (fetch_idx),
    .fetch_done_i   (fetch_done),
    .word_written_i (word_written),
    .busy_o         (busy_o),
    .done_o         (done_o)
  );

  word_fetch_unit u_fetch (
    .clk          (clk),
    .reset_n      (reset_n),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .fetch_idx_i  (fetch_idx),
    .fetch_done_o (fetch_done),
    .rd_cyc_o     (rd_cyc_o),
    .rd_stb_o     (rd_stb_o),
    .rd_adr_o     (rd_adr_o),
    .rd_dat_i     (rd_dat_i),
    .rd_ack_i     (rd_ack_i),
    .out_s        (fetch_stream.producer)
  );

  word_fifo #(
    .DEPTH (`CIPHER_FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .in_s    (fetch_stream.consumer),
    .out_s   (cipher_stream.producer)
  );

  cipher_writer u_writer (
    .clk            (clk),
    .reset_n        (reset_n),
    .in_s           (cipher_stream.consumer),
    .dst_base_i     (dst_base_i),
    .key_i          (key_i),
    .wr_cyc_o       (wr_cyc_o),
    .wr_stb_o       (wr_stb_o),
    .wr_we_o        (wr_we_o),
    .wr_adr_o       (wr_adr_o),
    .wr_dat_o       (wr_dat_o),
    .wr_ack_i       (wr_ack_i),
    .word_written_o (word_written)
  );

endmodule : cipher_accel_top

`default_nettype wire

// ==== tb/wb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

// Word memory with a Wishbone classic read port and write port
module wb_memory_model (
  input  wire logic                       clk,
  input  wire logic                       reset_n,
  input  wire logic [1:0]                 rd_max_dly_i,
  input  wire logic [1:0]                 wr_max_dly_i,
  input  wire logic [4:0]                 wr_extra_dly_i,
  input  wire logic                       rd_cyc_i,
  input  wire logic                       rd_stb_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  rd_adr_i,
  output logic      [`CIPHER_DATA_W-1:0]  rd_dat_o,
  output logic                            rd_ack_o,
  input  wire logic                       wr_cyc_i,
  input  wire logic                       wr_stb_i,
  input  wire logic                       wr_we_i,
  input  wire logic [`CIPHER_ADDR_W-1:0]  wr_adr_i,
  input  wire logic [`CIPHER_DATA_W-1:0]  wr_dat_i,
  output logic                            wr_ack_o
);

  logic [`CIPHER_DATA_W-1:0] mem [2**`CIPHER_ADDR_W];

  logic [5:0] rd_cnt_q;
  logic [5:0] rd_dly_q;
  logic [5:0] wr_cnt_q;
  logic [5:0] wr_dly_q;

  // Wait states for the next bus cycle
  function automatic logic [5:0] pick_delay(input logic [1:0] max_dly, input logic [4:0] extra);
    logic [5:0] spread;
    spread = 6'($urandom % (32'(max_dly) + 32'd1));
    return spread + 6'(extra);
  endfunction

  initial begin
    for (int a = 0; a < 2**`CIPHER_ADDR_W; a++) begin
      mem[a] = (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    end
  end

  assign rd_dat_o = mem[rd_adr_i];
  assign rd_ack_o = rd_cyc_i && rd_stb_i && (rd_cnt_q == rd_dly_q);
  assign wr_ack_o = wr_cyc_i && wr_stb_i && (wr_cnt_q == wr_dly_q);

  // Wait state counters with a new delay drawn between cycles
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_cnt_q <= '0;
      rd_dly_q <= '0;
      wr_cnt_q <= '0;
      wr_dly_q <= '0;
    end else begin
      if (rd_cyc_i && rd_stb_i && !rd_ack_o) begin
        rd_cnt_q <= rd_cnt_q + 6'd1;
      end else begin
        rd_cnt_q <= '0;
        rd_dly_q <= pick_delay(rd_max_dly_i, 5'd0);
      end
      if (wr_cyc_i && wr_stb_i && !wr_ack_o) begin
        wr_cnt_q <= wr_cnt_q + 6'd1;
      end else begin
        wr_cnt_q <= '0;
        wr_dly_q <= pick_delay(wr_max_dly_i, wr_extra_dly_i);
      end
    end
  end

  always @(posedge clk) begin
    if (wr_ack_o && wr_we_i) begin
      mem[wr_adr_i] = wr_dat_i;
    end
  end

endmodule : wb_memory_model

`default_nettype wire

// ==== tb/cipher_accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_settings.svh"

module cipher_accel_tb;

  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;
  localparam int WORDS           = `CIPHER_BLOCK_WORDS;

  logic                      clk = 1'b0;
  logic                      reset_n;
  logic                      start;
  logic [`CIPHER_ADDR_W-1:0] src_base;
  logic [`CIPHER_ADDR_W-1:0] dst_base;
  logic [`CIPHER_DATA_W-1:0] cipher_key;
  logic                      busy;
  logic                      done;
  logic                      rd_cyc;
  logic                      rd_stb;
  logic [`CIPHER_ADDR_W-1:0] rd_adr;
  logic [`CIPHER_DATA_W-1:0] rd_dat;
  logic                      rd_ack;
  logic                      wr_cyc;
  logic                      wr_stb;
  logic                      wr_we;
  logic [`CIPHER_ADDR_W-1:0] wr_adr;
  logic [`CIPHER_DATA_W-1:0] wr_dat;
  logic                      wr_ack;
  logic [1:0]                rd_max_dly;
  logic [1:0]                wr_max_dly;
  logic [4:0]                wr_extra_dly;

  // Current job as seen by the monitor and compare processes
  logic [`CIPHER_DATA_W-1:0] job_plain [WORDS];
  logic [`CIPHER_ADDR_W-1:0] job_src;
  logic [`CIPHER_ADDR_W-1:0] job_dst;
  logic [`CIPHER_DATA_W-1:0] job_key;
  logic [`CIPHER_ADDR_W-1:0] next_adr;
  logic                      in_job;
  int                        reads_seen;
  int                        writes_seen;
  int                        done_count;
  int                        error_count;
  int                        errors_at_test_start;
  int                        test_num;

  always #20 clk = ~clk;

  cipher_accel_top UUT (
    .clk (clk), .reset_n (reset_n), .start_i (start),
    .src_base_i (src_base), .dst_base_i (dst_base), .key_i (cipher_key),
    .busy_o (busy), .done_o (done),
    .rd_cyc_o (rd_cyc), .rd_stb_o (rd_stb), .rd_adr_o (rd_adr),
    .rd_dat_i (rd_dat), .rd_ack_i (rd_ack),
    .wr_cyc_o (wr_cyc), .wr_stb_o (wr_stb), .wr_we_o (wr_we),
    .wr_adr_o (wr_adr), .wr_dat_o (wr_dat), .wr_ack_i (wr_ack)
  );

  wb_memory_model u_mem (
    .clk (clk), .reset_n (reset_n),
    .rd_max_dly_i (rd_max_dly), .wr_max_dly_i (wr_max_dly), .wr_extra_dly_i (wr_extra_dly),
    .rd_cyc_i (rd_cyc), .rd_stb_i (rd_stb), .rd_adr_i (rd_adr),
    .rd_dat_o (rd_dat), .rd_ack_o (rd_ack),
    .wr_cyc_i (wr_cyc), .wr_stb_i (wr_stb), .wr_we_i (wr_we),
    .wr_adr_i (wr_adr), .wr_dat_i (wr_dat), .wr_ack_o (wr_ack)
  );

  // Expected ciphertext of one word
  function automatic logic [`CIPHER_DATA_W-1:0] expected_word(
    input logic [`CIPHER_DATA_W-1:0] plain,
    input logic [`CIPHER_DATA_W-1:0] key,
    input int                        idx
  );
    logic [`CIPHER_DATA_W-1:0] keyed;
    logic [`CIPHER_DATA_W-1:0] turned;
    keyed  = plain ^ key;
    turned = {keyed[`CIPHER_DATA_W-`CIPHER_ROT-1:0],
              keyed[`CIPHER_DATA_W-1:`CIPHER_DATA_W-`CIPHER_ROT]};
    return turned ^ `CIPHER_DATA_W'(idx);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic fill_random_block();
    for (int i = 0; i < WORDS; i++) begin
      job_plain[i] = $urandom;
    end
  endtask

  // One job with an optional second start pulse while busy
  task automatic run_job(input logic [`CIPHER_ADDR_W-1:0] src, input logic [`CIPHER_ADDR_W-1:0] dst,
                         input logic [`CIPHER_DATA_W-1:0] key, input bit restart);
    int done_before;
    @(posedge clk);
    #2;
    for (int i = 0; i < WORDS; i++) begin
      u_mem.mem[src + 16'(i)] = job_plain[i];
    end
    job_src     = src;
    job_dst     = dst;
    job_key     = key;
    src_base    = src;
    dst_base    = dst;
    cipher_key  = key;
    reads_seen  = 0;
    writes_seen = 0;
    done_before = done_count;
    start       = 1'b1;
    @(posedge clk);
    #2;
    start  = 1'b0;
    in_job = 1'b1;
    check_value("busy after start", 32'(busy), 32'd1);
    if (restart) begin
      repeat (3) @(posedge clk);
      #2;
      start = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
    end
    @(posedge clk);
    while (!done) @(posedge clk);
    #2;
    check_value("busy after done", 32'(busy), 32'd0);
    repeat (3) @(posedge clk);
    #2;
    check_value("done pulses in job", 32'(done_count - done_before), 32'd1);
  endtask

  task automatic end_test(input string name);
    int fails;
    fails = error_count - errors_at_test_start;
    test_num++;
    if (fails == 0) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      $display("Test %0d %s: %0d failed checks", test_num, name, fails);
    end
    errors_at_test_start = error_count;
  endtask

  // Bus cycle order and idle strobes with busy and done timing
  always @(posedge clk) begin
    if (reset_n) begin
      if (!busy) begin
        check_value("idle bus strobes", 32'({rd_cyc, rd_stb, wr_cyc, wr_stb}), 32'd0);
      end
      if (in_job) begin
        check_value("busy during job", 32'(busy), 32'd1);
      end
      if (rd_cyc && rd_stb && rd_ack) begin
        check_value("read address", 32'(rd_adr), 32'(job_src + 16'(reads_seen)));
        reads_seen++;
      end
      if (wr_cyc && wr_stb && wr_ack) begin
        next_adr = job_dst + 16'(writes_seen);
        check_value("write enable", 32'(wr_we), 32'd1);
        check_value("write address", 32'(wr_adr), 32'(next_adr));
        writes_seen++;
      end
      if (done) begin
        check_value("job running at done", 32'(in_job), 32'd1);
        check_value("writes before done", 32'(writes_seen), 32'(WORDS));
        done_count++;
        in_job = 1'b0;
      end
    end
  end

  // Sink words read back at the end of each job
  always @(posedge clk) begin
    if (reset_n && done) begin
      for (int i = 0; i < WORDS; i++) begin
        check_value("ciphertext word", u_mem.mem[job_dst + 16'(i)],
                    expected_word(job_plain[i], job_key, i));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h7182cd04));
    reset_n              = 1'b0;
    start                = 1'b0;
    src_base             = '0;
    dst_base             = '0;
    cipher_key           = '0;
    rd_max_dly           = 2'd0;
    wr_max_dly           = 2'd0;
    wr_extra_dly         = 5'd0;
    job_src              = '0;
    job_dst              = '0;
    job_key              = '0;
    next_adr             = '0;
    in_job               = 1'b0;
    reads_seen           = 0;
    writes_seen          = 0;
    done_count           = 0;
    error_count          = 0;
    errors_at_test_start = 0;
    test_num             = 0;
    repeat (2) @(posedge clk);
    #2;
    reset_n = 1'b1;

    job_plain[0] = 32'h0000_0001;
    job_plain[1] = 32'h8000_0000;
    job_plain[2] = 32'hdead_beef;
    job_plain[3] = 32'h1234_5678;
    run_job(16'h0100, 16'h0200, 32'h0, 1'b0);
    end_test("known block, zero key");

    rd_max_dly = 2'd3;
    wr_max_dly = 2'd3;
    for (int j = 0; j < 4; j++) begin
      fill_random_block();
      run_job({2'b00, 14'($urandom)}, {2'b10, 14'($urandom)}, $urandom, 1'b0);
    end
    end_test("random jobs");

    // Slow write acks queue words in the buffer
    rd_max_dly   = 2'd0;
    wr_max_dly   = 2'd1;
    wr_extra_dly = 5'd12;
    fill_random_block();
    run_job(16'h2000, 16'h9000, $urandom, 1'b0);
    end_test("slow write acks");

    rd_max_dly   = 2'd3;
    wr_max_dly   = 2'd3;
    wr_extra_dly = 5'd0;
    fill_random_block();
    run_job(16'h3000, 16'ha000, $urandom, 1'b0);
    end_test("done and busy timing");

    repeat (8) @(posedge clk);
    fill_random_block();
    run_job(16'h3100, 16'hb000, $urandom, 1'b1);
    end_test("idle buses and start while busy");

    $display("Tests run: %0d, failed checks: %0d", test_num, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : cipher_accel_tb

`default_nettype wire

// ==== cipher_accel_top.f ====
+incdir+source
source/cipher_pkg.sv
source/word_stream_if.sv
source/cipher_ctrl_fsm.sv
source/word_fetch_unit.sv
source/word_fifo.sv
source/cipher_writer.sv
source/cipher_accel_top.sv
tb/wb_memory_model.sv
tb/cipher_accel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module cipher_accel_tb \
  -f cipher_accel_top.f \
  -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vcipher_accel_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
